// ==== vlog.f ====
hw/core_pkg.sv
hw/wb_unit.sv
hw/reg_file.sv
hw/csr_file.sv
hw/wb_subsystem.sv
testbench/tb_wb_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the writeback subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

rm -f "$log_file"

verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module tb_wb_subsystem \
    --Mdir "$build_dir" \
    -o sim_wb
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

"./$build_dir/sim_wb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$log_file"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $log_file"
    exit 1
fi

// ==== testbench/tb_wb_subsystem.sv ====
`timescale 1ns/1ps

module tb_wb_subsystem;

    import core_pkg::*;

    localparam word_t tb_reset_pc    = 32'h0000_1000;
    localparam word_t tb_reset_mtvec = 32'h0000_2000;
    localparam int    wait_limit     = 64;   // Cycles per wait loop

    logic      clock;
    logic      reset;
    logic      lsu_valid;
    logic      lsu_ready;
    word_t     lsu_pc;
    word_t     lsu_dnpc;
    logic      lsu_jump;
    logic      lsu_branch;
    logic      lsu_wb;
    logic      lsu_csr_we;
    logic      lsu_ecall;
    logic      lsu_mret;
    reg_addr_t lsu_rd_addr;
    word_t     lsu_alu_res;
    word_t     lsu_csr_rdata;
    csr_addr_t lsu_csr_addr;
    logic      ifu_valid;
    logic      ifu_ready;
    word_t     ifu_dnpc;
    logic      ifu_jump;
    logic      ifu_branch;
    reg_addr_t ifu_rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    csr_addr_t csr_raddr;
    word_t     csr_rdata;

    word_t     lfsr_state;
    word_t     exp_regs [32];   // Register file model
    word_t     exp_mtvec;
    int        check_count;
    int        error_count;
    int        test_count;
    int        test_base;
    string     test_name;

    // Payload seen at the start of the last handover
    word_t     fetch_dnpc;
    logic      fetch_jump;
    logic      fetch_branch;
    reg_addr_t fetch_rd;

    wb_subsystem #(
        .reset_pc    (tb_reset_pc),
        .reset_mtvec (tb_reset_mtvec),
        .num_regs    (32)
    ) i_dut (.*);

    always #20 clock = ~clock;

    // ============================================================
    // Helpers
    // ============================================================

    function automatic word_t lfsr_next(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input word_t got, input word_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0d ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("Timeout: %s did not arrive within %0d cycles (at %0d ns)",
                 what, wait_limit, $time);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic wait_lsu_ready();
        int n;
        n = 0;
        while (lsu_ready !== 1'b1) begin
            if (n == wait_limit)
                timeout_abort("lsu_ready");
            next_cycle();
            n++;
        end
    endtask

    task automatic wait_ifu_valid();
        int n;
        n = 0;
        while (ifu_valid !== 1'b1) begin
            if (n == wait_limit)
                timeout_abort("ifu_valid");
            next_cycle();
            n++;
        end
    endtask

    task automatic clear_op();
        lsu_valid     = 1'b0;
        lsu_pc        = '0;
        lsu_dnpc      = '0;
        lsu_jump      = 1'b0;
        lsu_branch    = 1'b0;
        lsu_wb        = 1'b0;
        lsu_csr_we    = 1'b0;
        lsu_ecall     = 1'b0;
        lsu_mret      = 1'b0;
        lsu_rd_addr   = '0;
        lsu_alu_res   = '0;
        lsu_csr_rdata = '0;
        lsu_csr_addr  = '0;
    endtask

    task automatic drive_op(input word_t pc, input word_t dnpc, input logic wb,
                            input logic csr_we, input logic ecall, input logic mret,
                            input reg_addr_t rd, input word_t alu_res,
                            input word_t csr_old, input csr_addr_t csr_addr,
                            input logic jump, input logic branch);
        lsu_valid     = 1'b1;
        lsu_pc        = pc;
        lsu_dnpc      = dnpc;
        lsu_jump      = jump;
        lsu_branch    = branch;
        lsu_wb        = wb;
        lsu_csr_we    = csr_we;
        lsu_ecall     = ecall;
        lsu_mret      = mret;
        lsu_rd_addr   = rd;
        lsu_alu_res   = alu_res;
        lsu_csr_rdata = csr_old;
        lsu_csr_addr  = csr_addr;
    endtask

    // Accepted on the first edge in IDLE with lsu_valid high
    task automatic present_op(input word_t pc, input word_t dnpc, input logic wb,
                              input logic csr_we, input logic ecall, input logic mret,
                              input reg_addr_t rd, input word_t alu_res,
                              input word_t csr_old, input csr_addr_t csr_addr,
                              input logic jump, input logic branch);
        wait_lsu_ready();
        drive_op(pc, dnpc, wb, csr_we, ecall, mret, rd, alu_res, csr_old, csr_addr,
                 jump, branch);
        next_cycle();
        clear_op();
    endtask

    // Fetch side of the handover, with ifu_ready held low for stall cycles
    task automatic take_fetch(input int stall);
        int n;
        wait_ifu_valid();
        fetch_dnpc   = ifu_dnpc;
        fetch_jump   = ifu_jump;
        fetch_branch = ifu_branch;
        fetch_rd     = ifu_rd_addr;
        for (n = 0; n < stall; n++) begin
            next_cycle();
            check_value(word_t'(ifu_valid), 32'd1, "ifu_valid dropped while stalled");
            check_value(ifu_dnpc, fetch_dnpc, "ifu_dnpc changed while stalled");
            check_value(word_t'({ifu_jump, ifu_branch, ifu_rd_addr}),
                        word_t'({fetch_jump, fetch_branch, fetch_rd}),
                        "ifu flags changed while stalled");
            check_value(word_t'(lsu_ready), 32'd0, "lsu_ready high during handover");
        end
        ifu_ready = 1'b1;
        next_cycle();
        ifu_ready = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t a, output word_t d);
        rs1_addr = a;
        #1;
        d = rs1_data;
    endtask

    task automatic read_csr(input csr_addr_t a, output word_t d);
        csr_raddr = a;
        #1;
        d = csr_rdata;
    endtask

    task automatic test_begin(input string name);
        test_name = name;
        test_base = error_count;
        test_count++;
    endtask

    task automatic test_end();
        if (error_count == test_base)
            $display("%s: ok", test_name);
        else
            $display("%s: %0d check(s) failed", test_name, error_count - test_base);
    endtask

    // ============================================================
    // Tests
    // ============================================================

    task automatic test_reset_start();
        reset = 1'b1;
        repeat (16) next_cycle();
        check_value(word_t'({ifu_valid, lsu_ready}), 32'd0, "handshake outputs in reset");
        reset = 1'b0;
        take_fetch(3);
        check_value(fetch_dnpc, tb_reset_pc, "first ifu_dnpc");
        check_value(word_t'(fetch_rd), 32'd0, "first ifu_rd_addr");
        check_value(word_t'(lsu_ready), 32'd1, "lsu_ready after first handover");
    endtask

    task automatic test_reg_writeback();
        word_t     pc;
        word_t     data;
        word_t     v;
        word_t     fl;
        word_t     got;
        reg_addr_t r;
        pc = 32'h0000_1000;
        for (int i = 0; i < 8; i++) begin
            rand_bits(5, v);
            r = (v[4:0] == '0) ? 5'd1 : v[4:0];
            rand_bits(32, data);
            rand_bits(2, fl);
            rand_bits(2, v);
            present_op(pc, pc + 32'd4, 1'b1, 1'b0, 1'b0, 1'b0, r, data, '0, '0,
                       fl[1], fl[0]);
            take_fetch(int'(v));
            exp_regs[r] = data;
            check_value(fetch_dnpc, pc + 32'd4, "ifu_dnpc after writeback");
            check_value(word_t'(fetch_jump), word_t'(fl[1]), "ifu_jump after writeback");
            check_value(word_t'(fetch_branch), word_t'(fl[0]), "ifu_branch after writeback");
            check_value(word_t'(fetch_rd), word_t'(r), "ifu_rd_addr after writeback");
            read_reg(r, got);
            check_value(got, data, "rs1_data after writeback");
            pc = pc + 32'd4;
        end
        rand_bits(32, data);
        present_op(pc, pc + 32'd4, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, data, '0, '0,
                   1'b0, 1'b0);
        take_fetch(0);
        read_reg(5'd0, got);
        check_value(got, 32'd0, "x0 after write");
        for (int i = 1; i < 32; i++) begin   // Full sweep on the second port
            next_cycle();
            rs2_addr = 5'(i);
            #1;
            check_value(rs2_data, exp_regs[i], "rs2_data in register sweep");
        end
    endtask

    task automatic test_csr_swap();
        word_t     data;
        word_t     old;
        word_t     v;
        word_t     got;
        reg_addr_t r;
        rand_bits(5, v);
        r = (v[4:0] == '0) ? 5'd3 : v[4:0];
        rand_bits(32, data);
        read_csr(csr_mtvec, old);
        check_value(old, tb_reset_mtvec, "mtvec reset value");
        present_op(32'h1200, 32'h1204, 1'b1, 1'b1, 1'b0, 1'b0, r, data, old, csr_mtvec,
                   1'b0, 1'b0);
        take_fetch(0);
        exp_regs[r] = old;
        exp_mtvec   = data;
        check_value(word_t'(fetch_rd), word_t'(r), "ifu_rd_addr after swap");
        read_reg(r, got);
        check_value(got, old, "rd after mtvec swap");
        read_csr(csr_mtvec, got);
        check_value(got, data, "mtvec after swap");

        // Unimplemented CSR
        r = (r == 5'd31) ? 5'd1 : r + 5'd1;
        rand_bits(32, data);
        read_csr(12'h7c0, old);
        check_value(old, 32'd0, "unknown CSR before write");
        present_op(32'h1204, 32'h1208, 1'b1, 1'b1, 1'b0, 1'b0, r, data, old, 12'h7c0,
                   1'b0, 1'b0);
        take_fetch(1);
        exp_regs[r] = old;
        read_csr(12'h7c0, got);
        check_value(got, 32'd0, "unknown CSR after write");
        read_reg(r, got);
        check_value(got, 32'd0, "rd after unknown CSR swap");
    endtask

    task automatic test_trap_return();
        word_t pc;
        word_t status;
        word_t v;
        word_t got;
        read_csr(csr_mstatus, got);
        present_op(32'h1300, 32'h1304, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0, 32'h8, got, csr_mstatus,
                   1'b0, 1'b0);
        take_fetch(0);
        status = 32'h0000_0008;   // mie set
        read_csr(csr_mstatus, got);
        check_value(got, status, "mstatus before ecall");

        rand_bits(32, v);
        pc = {v[31:2], 2'b00};
        present_op(pc, pc + 32'd4, 1'b0, 1'b0, 1'b1, 1'b0, 5'd0, '0, '0, '0,
                   1'b0, 1'b0);
        take_fetch(1);
        check_value(fetch_dnpc, exp_mtvec, "ifu_dnpc after ecall");
        check_value(word_t'(fetch_rd), 32'd0, "ifu_rd_addr after ecall");
        status[7]     = status[3];
        status[3]     = 1'b0;
        status[12:11] = 2'b11;
        read_csr(csr_mepc, got);
        check_value(got, pc, "mepc after ecall");
        read_csr(csr_mcause, got);
        check_value(got, 32'd11, "mcause after ecall");
        read_csr(csr_mstatus, got);
        check_value(got, status, "mstatus after ecall");

        present_op(exp_mtvec, exp_mtvec + 32'd4, 1'b0, 1'b0, 1'b0, 1'b1, 5'd0, '0, '0, '0,
                   1'b0, 1'b0);
        take_fetch(2);
        check_value(fetch_dnpc, pc, "ifu_dnpc after mret");
        status[3] = status[7];
        status[7] = 1'b1;
        read_csr(csr_mstatus, got);
        check_value(got, status, "mstatus after mret");
    endtask

    task automatic test_back_pressure();
        word_t     pc;
        word_t     va;
        word_t     vb;
        word_t     v;
        word_t     got;
        reg_addr_t ra;
        reg_addr_t rb;
        pc = 32'h0000_1400;
        for (int round = 0; round < 4; round++) begin
            rand_bits(5, v);
            ra = (v[4:0] == '0) ? 5'd1 : v[4:0];
            rb = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
            rand_bits(32, va);
            rand_bits(32, vb);
            rand_bits(3, v);
            present_op(pc, pc + 32'd4, 1'b1, 1'b0, 1'b0, 1'b0, ra, va, '0, '0,
                       1'b0, 1'b0);
            // Second instruction waits through the stall
            drive_op(pc + 32'd4, pc + 32'd8, 1'b1, 1'b0, 1'b0, 1'b0, rb, vb, '0, '0,
                     1'b0, 1'b0);
            take_fetch(int'(v) + 1);
            check_value(fetch_dnpc, pc + 32'd4, "first ifu_dnpc under stall");
            check_value(word_t'(fetch_rd), word_t'(ra), "first ifu_rd_addr under stall");
            read_reg(rb, got);
            check_value(got, exp_regs[rb], "second write landed early");
            next_cycle();
            clear_op();
            take_fetch(0);
            exp_regs[ra] = va;
            exp_regs[rb] = vb;
            check_value(fetch_dnpc, pc + 32'd8, "second ifu_dnpc");
            check_value(word_t'(fetch_rd), word_t'(rb), "second ifu_rd_addr");
            read_reg(ra, got);
            check_value(got, va, "first register value");
            read_reg(rb, got);
            check_value(got, vb, "second register value");
            repeat (3) begin
                next_cycle();
                check_value(word_t'({ifu_valid, lsu_ready}), 32'd1, "extra handover");
            end
            pc = pc + 32'd8;
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        ifu_ready   = 1'b0;
        rs1_addr    = '0;
        rs2_addr    = '0;
        csr_raddr   = '0;
        clear_op();
        lfsr_state  = 32'hcabf_a680;
        exp_mtvec   = tb_reset_mtvec;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        for (int i = 0; i < 32; i++)
            exp_regs[i] = '0;

        test_begin("reset_start");
        test_reset_start();
        test_end();
        test_begin("reg_writeback");
        test_reg_writeback();
        test_end();
        test_begin("csr_swap");
        test_csr_swap();
        test_end();
        test_begin("trap_return");
        test_trap_return();
        test_end();
        test_begin("back_pressure");
        test_back_pressure();
        test_end();

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== hw/wb_subsystem.sv ====
`timescale 1ns/1ps

module wb_subsystem #(
    parameter core_pkg::word_t reset_pc    = 32'h8000_0000,
    parameter core_pkg::word_t reset_mtvec = 32'h8000_0100,
    parameter int              num_regs    = 32
) (
    input  logic                clock,
    input  logic                reset,

    // Load/store stage
    input  logic                lsu_valid,
    output logic                lsu_ready,
    input  core_pkg::word_t     lsu_pc,
    input  core_pkg::word_t     lsu_dnpc,
    input  logic                lsu_jump,
    input  logic                lsu_branch,
    input  logic                lsu_wb,
    input  logic                lsu_csr_we,
    input  logic                lsu_ecall,
    input  logic                lsu_mret,
    input  core_pkg::reg_addr_t lsu_rd_addr,
    input  core_pkg::word_t     lsu_alu_res,
    input  core_pkg::word_t     lsu_csr_rdata,
    input  core_pkg::csr_addr_t lsu_csr_addr,

    // Fetch
    output logic                ifu_valid,
    input  logic                ifu_ready,
    output core_pkg::word_t     ifu_dnpc,
    output logic                ifu_jump,
    output logic                ifu_branch,
    output core_pkg::reg_addr_t ifu_rd_addr,

    // Decode read ports
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  core_pkg::csr_addr_t csr_raddr,
    output core_pkg::word_t     csr_rdata
);

    import core_pkg::*;

    reg_addr_t rd;
    word_t     wdata;
    logic      we;
    logic      csr_we;
    csr_addr_t csr_waddr;
    word_t     csr_wdata;
    logic      trap;
    word_t     trap_pc;
    logic      trap_ret;
    word_t     mtvec;
    word_t     mepc;

    wb_unit #(
        .reset_pc (reset_pc)
    ) u_wb_unit (
        .clock         (clock),
        .reset         (reset),
        .lsu_valid     (lsu_valid),
        .lsu_ready     (lsu_ready),
        .lsu_pc        (lsu_pc),
        .lsu_dnpc      (lsu_dnpc),
        .lsu_jump      (lsu_jump),
        .lsu_branch    (lsu_branch),
        .lsu_wb        (lsu_wb),
        .lsu_csr_we    (lsu_csr_we),
        .lsu_ecall     (lsu_ecall),
        .lsu_mret      (lsu_mret),
        .lsu_rd_addr   (lsu_rd_addr),
        .lsu_alu_res   (lsu_alu_res),
        .lsu_csr_rdata (lsu_csr_rdata),
        .lsu_csr_addr  (lsu_csr_addr),
        .rd            (rd),
        .wdata         (wdata),
        .we            (we),
        .csr_we        (csr_we),
        .csr_waddr     (csr_waddr),
        .csr_wdata     (csr_wdata),
        .trap          (trap),
        .trap_pc       (trap_pc),
        .trap_ret      (trap_ret),
        .mtvec         (mtvec),
        .mepc          (mepc),
        .ifu_valid     (ifu_valid),
        .ifu_ready     (ifu_ready),
        .ifu_dnpc      (ifu_dnpc),
        .ifu_jump      (ifu_jump),
        .ifu_branch    (ifu_branch),
        .ifu_rd_addr   (ifu_rd_addr)
    );

    reg_file #(
        .num_regs (num_regs)
    ) u_reg_file (
        .clock   (clock),
        .reset   (reset),
        .we      (we),
        .waddr   (rd),
        .wdata   (wdata),
        .raddr_a (rs1_addr),
        .raddr_b (rs2_addr),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    csr_file #(
        .reset_mtvec (reset_mtvec)
    ) u_csr_file (
        .clock     (clock),
        .reset     (reset),
        .csr_we    (csr_we),
        .csr_waddr (csr_waddr),
        .csr_wdata (csr_wdata),
        .csr_raddr (csr_raddr),
        .csr_rdata (csr_rdata),
        .trap      (trap),
        .trap_pc   (trap_pc),
        .trap_ret  (trap_ret),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

endmodule

// ==== hw/csr_file.sv ====
`timescale 1ns/1ps

module csr_file #(
    parameter core_pkg::word_t reset_mtvec = 32'h0000_0000
) (
    input  logic                clock,
    input  logic                reset,

    // Software write port
    input  logic                csr_we,
    input  core_pkg::csr_addr_t csr_waddr,
    input  core_pkg::word_t     csr_wdata,

    // Read port for decode
    input  core_pkg::csr_addr_t csr_raddr,
    output core_pkg::word_t     csr_rdata,

    // Trap entry and return
    input  logic                trap,
    input  core_pkg::word_t     trap_pc,
    input  logic                trap_ret,

    output core_pkg::word_t     mtvec,
    output core_pkg::word_t     mepc
);

    import core_pkg::*;

    mstatus_t mstatus;
    word_t    mcause;

    // ============================================================
    // Read mux
    // ============================================================

    always_comb begin
        unique case (csr_raddr)
            csr_mstatus: csr_rdata = mstatus.raw;
            csr_mtvec:   csr_rdata = mtvec;
            csr_mepc:    csr_rdata = mepc;
            csr_mcause:  csr_rdata = mcause;
            default:     csr_rdata = '0;  // Unimplemented
        endcase
    end

    // ============================================================
    // Updates
    // ============================================================

    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus.raw <= '0;
            mtvec       <= reset_mtvec;
            mepc        <= '0;
            mcause      <= '0;
        end else if (trap) begin
            // Only ecall traps reach here
            mepc             <= trap_pc;
            mcause           <= mcause_ecall_m;
            mstatus.f.mpie   <= mstatus.f.mie;
            mstatus.f.mie    <= 1'b0;
            mstatus.f.mpp    <= priv_m;
        end else if (trap_ret) begin
            mstatus.f.mie    <= mstatus.f.mpie;
            mstatus.f.mpie   <= 1'b1;
        end else if (csr_we) begin
            case (csr_waddr)
                csr_mstatus: mstatus.raw <= csr_wdata;
                csr_mtvec:   mtvec       <= csr_wdata;
                csr_mepc:    mepc        <= csr_wdata;
                csr_mcause:  mcause      <= csr_wdata;
                default:     ;                          // Write dropped
            endcase
        end
    end

    // One instruction commits at most one of these
    a_trap_excl: assert property (@(posedge clock) disable iff (reset)
        !(trap && trap_ret))
        else $error("trap and trap return in the same cycle");

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter int num_regs = 32
) (
    input  logic                clock,
    input  logic                reset,

    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata,

    input  core_pkg::reg_addr_t raddr_a,
    input  core_pkg::reg_addr_t raddr_b,
    output core_pkg::word_t     rdata_a,
    output core_pkg::word_t     rdata_b
);

    import core_pkg::*;

    word_t regs [num_regs];

    logic wr_ok;
    logic rd_ok_a;
    logic rd_ok_b;

    // x0 and out-of-range indices are inert
    assign wr_ok   = we && (waddr != '0) && (waddr < num_regs);
    assign rd_ok_a = (raddr_a != '0) && (raddr_a < num_regs);
    assign rd_ok_b = (raddr_b != '0) && (raddr_b < num_regs);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (wr_ok) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational read ports
    assign rdata_a = rd_ok_a ? regs[raddr_a] : '0;
    assign rdata_b = rd_ok_b ? regs[raddr_b] : '0;

    // RV32E decode must never produce x16..x31
    a_waddr_range: assert property (@(posedge clock) disable iff (reset)
        we |-> (waddr < num_regs))
        else $error("register write beyond num_regs");

endmodule

// ==== hw/wb_unit.sv ====
`timescale 1ns/1ps

module wb_unit #(
    parameter core_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic                clock,
    input  logic                reset,

    // Load/store stage side
    input  logic                lsu_valid,
    output logic                lsu_ready,
    input  core_pkg::word_t     lsu_pc,
    input  core_pkg::word_t     lsu_dnpc,
    input  logic                lsu_jump,
    input  logic                lsu_branch,
    input  logic                lsu_wb,
    input  logic                lsu_csr_we,
    input  logic                lsu_ecall,
    input  logic                lsu_mret,
    input  core_pkg::reg_addr_t lsu_rd_addr,
    input  core_pkg::word_t     lsu_alu_res,
    input  core_pkg::word_t     lsu_csr_rdata,
    input  core_pkg::csr_addr_t lsu_csr_addr,

    // Register file write port
    output core_pkg::reg_addr_t rd,
    output core_pkg::word_t     wdata,
    output logic                we,

    // CSR file control
    output logic                csr_we,
    output core_pkg::csr_addr_t csr_waddr,
    output core_pkg::word_t     csr_wdata,
    output logic                trap,
    output core_pkg::word_t     trap_pc,
    output logic                trap_ret,
    input  core_pkg::word_t     mtvec,
    input  core_pkg::word_t     mepc,

    // Fetch side
    output logic                ifu_valid,
    input  logic                ifu_ready,
    output core_pkg::word_t     ifu_dnpc,
    output logic                ifu_jump,
    output logic                ifu_branch,
    output core_pkg::reg_addr_t ifu_rd_addr
);

    import core_pkg::*;

    enum logic [1:0] {
        IDLE,
        EXEC,
        WAIT,
        RST
    } state, state_next;

    logic  accept;
    logic  commit_rd;   // Instruction writes an integer register
    logic  commit_csr;
    word_t next_pc;

    assign accept     = (state == IDLE) && lsu_valid;
    assign commit_rd  = !lsu_ecall && !lsu_mret && (lsu_wb || lsu_csr_we);
    assign commit_csr = !lsu_ecall && !lsu_mret && lsu_csr_we;

    always_comb begin
        if (lsu_ecall)
            next_pc = mtvec;
        else if (lsu_mret)
            next_pc = mepc;
        else
            next_pc = lsu_dnpc;
    end

    // ============================================================
    // State machine
    // ============================================================

    always_ff @(posedge clock) begin
        if (reset)
            state <= RST;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE:       if (lsu_valid) state_next = EXEC;
            EXEC, WAIT: state_next = ifu_ready ? IDLE : WAIT;
            RST:        state_next = WAIT;  // First fetch handover
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            lsu_ready <= 1'b0;
            ifu_valid <= 1'b0;
        end else begin
            unique case (state)
                IDLE: begin
                    lsu_ready <= !lsu_valid;
                    ifu_valid <= lsu_valid;
                end
                EXEC, WAIT: begin
                    lsu_ready <= ifu_ready;
                    ifu_valid <= !ifu_ready;
                end
                RST: begin
                    lsu_ready <= 1'b0;
                    ifu_valid <= 1'b1;
                end
            endcase
        end
    end

    // ============================================================
    // Commit pulses and payload
    // ============================================================

    always_ff @(posedge clock) begin
        if (reset) begin
            we       <= 1'b0;
            csr_we   <= 1'b0;
            trap     <= 1'b0;
            trap_ret <= 1'b0;
        end else begin
            we       <= accept && commit_rd;
            csr_we   <= accept && commit_csr;
            trap     <= accept && lsu_ecall;
            trap_ret <= accept && !lsu_ecall && lsu_mret;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            rd        <= lsu_rd_addr;
            wdata     <= lsu_csr_we ? lsu_csr_rdata : lsu_alu_res;  // Swap returns old CSR
            csr_waddr <= lsu_csr_addr;
            csr_wdata <= lsu_alu_res;
            trap_pc   <= lsu_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (state == RST) begin
            ifu_dnpc    <= reset_pc;
            ifu_jump    <= 1'b0;
            ifu_branch  <= 1'b0;
            ifu_rd_addr <= '0;
        end else if (accept) begin
            ifu_dnpc    <= next_pc;
            ifu_jump    <= lsu_jump || lsu_ecall || lsu_mret;  // Trap redirects too
            ifu_branch  <= lsu_branch;
            ifu_rd_addr <= commit_rd ? lsu_rd_addr : '0;
        end
    end

    // Handover to fetch holds until taken
    a_ifu_hold: assert property (@(posedge clock) disable iff (reset)
        ifu_valid && !ifu_ready |=> ifu_valid &&
            $stable({ifu_dnpc, ifu_jump, ifu_branch, ifu_rd_addr}))
        else $error("ifu payload changed under back-pressure");

    a_we_trap: assert property (@(posedge clock) disable iff (reset) !(we && trap))
        else $error("register write during trap");

endmodule

// ==== hw/core_pkg.sv ====
package core_pkg;

    // ============================================================
    // Basic word and address types
    // ============================================================

    typedef logic [31:0] word_t;      // Data word or PC
    typedef logic [4:0]  reg_addr_t;  // Integer register index
    typedef logic [11:0] csr_addr_t;

    // ============================================================
    // Machine-mode CSR addresses
    // ============================================================

    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;
    localparam csr_addr_t csr_mcause  = 12'h342;

    // Environment call from M-mode
    localparam word_t mcause_ecall_m = 32'd11;

    // ============================================================
    // mstatus, seen as a raw word or as its fields
    // ============================================================

    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;         // Bits 12:11
        logic [2:0]  rsvd_10_8;
        logic        mpie;        // Bit 7
        logic [2:0]  rsvd_6_4;
        logic        mie;         // Bit 3
        logic [2:0]  rsvd_2_0;
    } mstatus_fields_t;

    // Software access goes through raw, trap logic through f
    typedef union packed {
        word_t           raw;
        mstatus_fields_t f;
    } mstatus_t;

    localparam logic [1:0] priv_m = 2'b11;

endpackage
